/* sim.f */
+incdir+verification
common/mips_pkg.sv
common/dmem_if.sv
hw/mem_stage/mem_stage.sv
hw/cp0/cp0_regs.sv
hw/mem_wb_reg.sv
hw/data_ram.sv
hw/mem_subsys_top.sv
verification/mem_subsys_tb.sv

/* verification/mem_subsys_model.svh */
`ifndef MEM_SUBSYS_MODEL_SVH
`define MEM_SUBSYS_MODEL_SVH

word_t     m_mem [DMEM_DEPTH];
word_t     m_status;
word_t     m_cause;
word_t     m_epc;
// mtc0 held in the MEM/WB register
logic      m_wb_we;
reg_addr_t m_wb_waddr;
word_t     m_wb_wdata;

task automatic clear_model();
    m_status   = '0;
    m_cause    = '0;
    m_epc      = '0;
    m_wb_we    = 1'b0;
    m_wb_waddr = '0;
    m_wb_wdata = '0;
endtask

// CP0 as the memory stage sees it with the writeback mtc0 on top
task automatic cp0_seen_by_stage(output word_t st, output word_t ca, output word_t ep);
    st = m_status;
    ca = m_cause;
    ep = m_epc;
    if (m_wb_we && m_wb_waddr == CP0_STATUS) begin
        st = m_wb_wdata;
    end
    if (m_wb_we && m_wb_waddr == CP0_CAUSE) begin
        ca[9:8] = m_wb_wdata[9:8];
    end
    if (m_wb_we && m_wb_waddr == CP0_EPC) begin
        ep = m_wb_wdata;
    end
endtask

function automatic word_t resolve_exception(input word_t flags, input word_t inst_pc,
                                            input word_t st, input word_t ca);
    logic  irq_taken;
    word_t code;
    irq_taken = (|(st[15:8] & ca[15:8])) && !st[1] && st[0];
    code = EXCP_NONE;
    if (inst_pc == PC_RESET_ADDR) begin
        code = EXCP_NONE;
    end else if (irq_taken) begin
        code = EXCP_INTERRUPT;
    end else if (flags[8]) begin
        code = EXCP_SYSCALL;
    end else if (flags[9]) begin
        code = EXCP_INVALID_INST;
    end else if (flags[11]) begin
        code = EXCP_OV;
    end else if (flags[12]) begin
        code = EXCP_ERET;
    end
    return code;
endfunction

function automatic word_t extract_load(input oper_t op, input word_t addr, input word_t pass);
    word_t       w;
    logic [7:0]  b;
    logic [15:0] h;
    w = m_mem[addr[9:2]];
    b = w[8*addr[1:0] +: 8];
    h = w[16*addr[1] +: 16];
    case (op)
        OP_LB:   return {{24{b[7]}}, b};
        OP_LBU:  return {24'b0, b};
        OP_LH:   return addr[0] ? '0 : {{16{h[15]}}, h};
        OP_LHU:  return addr[0] ? '0 : {16'b0, h};
        OP_LW:   return w;
        default: return pass;
    endcase
endfunction

// state change at the rising edge that ends the presenting cycle
task automatic commit_edge(
    input oper_t     op,
    input word_t     addr,
    input word_t     wdata,
    input logic      we_cp0,
    input reg_addr_t waddr_cp0,
    input word_t     wdata_cp0,
    input word_t     code,
    input word_t     inst_pc,
    input logic      in_ds,
    input hw_int_t   hw_irq
);
    if (code == EXCP_NONE) begin
        case (op)
            OP_SB: begin
                m_mem[addr[9:2]][8*addr[1:0] +: 8] = wdata[7:0];
            end
            OP_SH: begin
                if (!addr[0]) begin
                    m_mem[addr[9:2]][16*addr[1] +: 16] = wdata[15:0];
                end
            end
            OP_SW: begin
                m_mem[addr[9:2]] = wdata;
            end
            default: begin
            end
        endcase
    end
    if (m_wb_we && m_wb_waddr == CP0_STATUS) begin
        m_status = m_wb_wdata;
    end
    if (m_wb_we && m_wb_waddr == CP0_CAUSE) begin
        m_cause[9:8] = m_wb_wdata[9:8];
    end
    if (m_wb_we && m_wb_waddr == CP0_EPC) begin
        m_epc = m_wb_wdata;
    end
    // exception record lands after the mtc0
    if (code == EXCP_ERET) begin
        m_status[1] = 1'b0;
    end else if (code != EXCP_NONE) begin
        m_status[1]   = 1'b1;
        m_cause[6:2]  = (code == EXCP_INTERRUPT) ? 5'd0 : code[4:0];
        m_cause[31]   = in_ds;
        m_epc         = in_ds ? inst_pc - 32'd4 : inst_pc;
    end
    m_cause[15:10] = hw_irq;
    m_wb_we    = we_cp0 && (code == EXCP_NONE);
    m_wb_waddr = waddr_cp0;
    m_wb_wdata = wdata_cp0;
endtask

`endif

/* verification/mem_subsys_tb.sv */
`timescale 1ns/1ps

module mem_subsys_tb
    import mips_pkg::*;
();

    localparam logic [31:0] SEED          = 32'hdb12_d6e5;
    localparam int          WAIT_SLACK    = 4;
    localparam word_t       EXC_FLAG_MASK = 32'h0000_1b00;

    logic      clk;
    logic      reset;
    hw_int_t   irq;
    oper_t     oper;
    word_t     mem_addr;
    word_t     mem_wdata;
    logic      wreg_write;
    reg_addr_t wreg_addr;
    word_t     wreg_data;
    logic      whilo;
    word_t     hi;
    word_t     lo;
    logic      cp0_we;
    reg_addr_t cp0_waddr;
    word_t     cp0_wdata;
    word_t     exc_flags;
    word_t     pc;
    logic      delay_slot;

    logic      wb_wreg_write;
    reg_addr_t wb_wreg_addr;
    word_t     wb_wreg_data;
    logic      wb_whilo;
    word_t     wb_hi;
    word_t     wb_lo;
    word_t     wb_exception_type;
    word_t     cp0_epc;

    int    cycle_cnt = 0;
    int    n_checks  = 0;
    int    err_word  = 0;
    int    err_reg   = 0;
    int    err_bit   = 0;
    string cur_test  = "init";

    oper_t mem_ops [8] = '{OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW};
    oper_t exc_ops [5] = '{OP_NONE, OP_SB, OP_SH, OP_SW, OP_LW};

    `include "mem_subsys_model.svh"

    mem_subsys_top u_dut (
        .clk                 (clk),
        .reset_i             (reset),
        .int_i               (irq),
        .oper_i              (oper),
        .mem_addr_i          (mem_addr),
        .mem_wdata_i         (mem_wdata),
        .wreg_write_i        (wreg_write),
        .wreg_addr_i         (wreg_addr),
        .wreg_data_i         (wreg_data),
        .whilo_i             (whilo),
        .hi_i                (hi),
        .lo_i                (lo),
        .cp0_we_i            (cp0_we),
        .cp0_waddr_i         (cp0_waddr),
        .cp0_wdata_i         (cp0_wdata),
        .exception_type_i    (exc_flags),
        .pc_i                (pc),
        .is_in_delayslot_i   (delay_slot),
        .wb_wreg_write_o     (wb_wreg_write),
        .wb_wreg_addr_o      (wb_wreg_addr),
        .wb_wreg_data_o      (wb_wreg_data),
        .wb_whilo_o          (wb_whilo),
        .wb_hi_o             (wb_hi),
        .wb_lo_o             (wb_lo),
        .wb_exception_type_o (wb_exception_type),
        .cp0_epc_o           (cp0_epc)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic check_word(input string what, input word_t exp, input word_t act);
        n_checks++;
        if (act !== exp) begin
            err_word++;
            $display("Error: %s %s expected %h actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_reg(input string what, input reg_addr_t exp, input reg_addr_t act);
        n_checks++;
        if (act !== exp) begin
            err_reg++;
            $display("Error: %s %s expected %h actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        n_checks++;
        if (act !== exp) begin
            err_bit++;
            $display("Error: %s %s expected %b actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic print_counts();
        $display("%0d checks, errors: word %0d, reg %0d, bit %0d",
                 n_checks, err_word, err_reg, err_bit);
    endtask

    // returns on the falling edge after n rising edges
    task automatic wait_cycles(input int n);
        int start;
        int guard;
        start = cycle_cnt;
        guard = 0;
        while (cycle_cnt < start + n && guard < n + WAIT_SLACK) begin
            @(negedge clk);
            guard++;
        end
        if (cycle_cnt < start + n) begin
            $display("timeout in %s: the clock stopped advancing", cur_test);
            print_counts();
            $display("Test failed");
            $finish;
        end
    endtask

    task automatic random_fields();
        oper       = OP_NONE;
        mem_addr   = $urandom;
        mem_wdata  = $urandom;
        wreg_write = 1'($urandom);
        wreg_addr  = 5'($urandom);
        wreg_data  = $urandom;
        whilo      = 1'($urandom);
        hi         = $urandom;
        lo         = $urandom;
        cp0_we     = 1'b0;
        cp0_waddr  = 5'($urandom);
        cp0_wdata  = $urandom;
        exc_flags  = '0;
        pc         = 32'h8000_0000 | ($urandom & 32'h000f_fffc);
        delay_slot = 1'($urandom);
    endtask

    // present one instruction, then compare its writeback results
    task automatic issue();
        word_t st;
        word_t ca;
        word_t ep;
        word_t code;
        word_t load_val;
        cp0_seen_by_stage(st, ca, ep);
        code     = resolve_exception(exc_flags, pc, st, ca);
        load_val = extract_load(oper, mem_addr, wreg_data);
        wait_cycles(1);
        commit_edge(oper, mem_addr, mem_wdata, cp0_we, cp0_waddr, cp0_wdata,
                    code, pc, delay_slot, irq);
        cp0_seen_by_stage(st, ca, ep);
        check_bit("wb_wreg_write", wreg_write && code == EXCP_NONE, wb_wreg_write);
        check_reg("wb_wreg_addr", wreg_addr, wb_wreg_addr);
        check_word("wb_wreg_data", load_val, wb_wreg_data);
        check_bit("wb_whilo", whilo && code == EXCP_NONE, wb_whilo);
        check_word("wb_hi", hi, wb_hi);
        check_word("wb_lo", lo, wb_lo);
        check_word("wb_exception_type", code, wb_exception_type);
        check_word("cp0_epc", ep, cp0_epc);
    endtask

    // mtc0 from the reset address, which never takes an interrupt
    task automatic write_cp0(input reg_addr_t sel, input word_t value);
        random_fields();
        pc        = PC_RESET_ADDR;
        cp0_we    = 1'b1;
        cp0_waddr = sel;
        cp0_wdata = value;
        issue();
    endtask

    initial begin
        int          i;
        word_t       epc_val;
        int unsigned rng_init;
        rng_init = $urandom(SEED);
        reset = 1'b1;
        irq   = '0;
        random_fields();
        clear_model();

        cur_test = "reset";
        wait_cycles(4);
        check_bit("wb_wreg_write", 1'b0, wb_wreg_write);
        check_reg("wb_wreg_addr", '0, wb_wreg_addr);
        check_word("wb_wreg_data", '0, wb_wreg_data);
        check_bit("wb_whilo", 1'b0, wb_whilo);
        check_word("wb_hi", '0, wb_hi);
        check_word("wb_lo", '0, wb_lo);
        check_word("wb_exception_type", EXCP_NONE, wb_exception_type);
        check_word("cp0_epc", '0, cp0_epc);
        reset = 1'b0;

        // every word defined before any load
        cur_test = "fill";
        for (i = 0; i < DMEM_DEPTH; i++) begin
            random_fields();
            oper     = OP_SW;
            mem_addr = i << 2;
            issue();
        end

        cur_test = "load_store";
        for (i = 0; i < 200; i++) begin
            random_fields();
            oper     = mem_ops[$urandom_range(0, 7)];
            mem_addr = $urandom & 32'h0000_03ff;
            if (oper inside {OP_LH, OP_LHU, OP_SH}) begin
                mem_addr[0] = 1'b0;
            end else if (oper inside {OP_LW, OP_SW}) begin
                mem_addr[1:0] = 2'b00;
            end
            issue();
        end

        cur_test = "misaligned";
        for (i = 0; i < 18; i++) begin
            random_fields();
            oper     = (i % 3 == 0) ? OP_SH : ((i % 3 == 1) ? OP_LH : OP_LHU);
            mem_addr = ($urandom & 32'h0000_03fe) | 32'h1;
            issue();
            if (oper != OP_SH) begin
                check_word("odd halfword data", '0, wb_wreg_data);
            end
            oper     = OP_LW;
            mem_addr = mem_addr & ~32'h3;
            issue();
        end

        cur_test = "exceptions";
        for (i = 0; i < 200; i++) begin
            random_fields();
            irq       = hw_int_t'($urandom);
            exc_flags = $urandom & EXC_FLAG_MASK;
            oper      = exc_ops[$urandom_range(0, 4)];
            mem_addr  = $urandom & 32'h0000_03fc;
            if ($urandom_range(0, 7) == 0) begin
                pc = PC_RESET_ADDR;
            end
            if ($urandom_range(0, 3) == 0) begin
                cp0_we    = 1'b1;
                cp0_waddr = reg_addr_t'(CP0_STATUS + $urandom_range(0, 2));
            end
            issue();
        end

        cur_test = "interrupt";
        irq = '0;
        write_cp0(CP0_STATUS, '0);
        write_cp0(CP0_CAUSE, '0);
        write_cp0(CP0_STATUS, 32'h0000_ff01);
        random_fields();
        pc  = PC_RESET_ADDR;
        irq = 6'b000100;
        issue();
        random_fields();
        pc = PC_RESET_ADDR;
        issue();
        check_word("no interrupt at reset pc", EXCP_NONE, wb_exception_type);
        random_fields();
        issue();
        check_word("interrupt taken", EXCP_INTERRUPT, wb_exception_type);
        check_word("interrupt epc", delay_slot ? pc - 32'd4 : pc, cp0_epc);
        random_fields();
        issue();
        check_word("masked while exl", EXCP_NONE, wb_exception_type);
        random_fields();
        oper      = OP_ERET;
        exc_flags = 32'h1 << EXC_BIT_ERET;
        issue();
        check_word("eret", EXCP_ERET, wb_exception_type);
        random_fields();
        issue();
        check_word("interrupt after eret", EXCP_INTERRUPT, wb_exception_type);
        irq = '0;
        write_cp0(CP0_STATUS, '0);

        cur_test = "epc_write";
        epc_val = $urandom & 32'hffff_fffc;
        random_fields();
        cp0_we    = 1'b1;
        cp0_waddr = CP0_EPC;
        cp0_wdata = epc_val;
        issue();
        random_fields();
        issue();
        check_word("epc after writeback", epc_val, cp0_epc);

        // catches stores that should have been dropped
        cur_test = "sweep";
        for (i = 0; i < DMEM_DEPTH; i++) begin
            random_fields();
            oper     = OP_LW;
            mem_addr = i << 2;
            issue();
        end

        print_counts();
        if (err_word + err_reg + err_bit == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* hw/mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top
    import mips_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  hw_int_t   int_i,

    input  oper_t     oper_i,
    input  word_t     mem_addr_i,
    input  word_t     mem_wdata_i,
    input  logic      wreg_write_i,
    input  reg_addr_t wreg_addr_i,
    input  word_t     wreg_data_i,
    input  logic      whilo_i,
    input  word_t     hi_i,
    input  word_t     lo_i,
    input  logic      cp0_we_i,
    input  reg_addr_t cp0_waddr_i,
    input  word_t     cp0_wdata_i,
    input  word_t     exception_type_i,
    input  word_t     pc_i,
    input  logic      is_in_delayslot_i,

    output logic      wb_wreg_write_o,
    output reg_addr_t wb_wreg_addr_o,
    output word_t     wb_wreg_data_o,
    output logic      wb_whilo_o,
    output word_t     wb_hi_o,
    output word_t     wb_lo_o,
    output word_t     wb_exception_type_o,
    output word_t     cp0_epc_o
);

    dmem_if dmem ();

    // stage to MEM/WB
    logic      mem_wreg_write;
    reg_addr_t mem_wreg_addr;
    word_t     mem_wreg_data;
    logic      mem_whilo;
    word_t     mem_hi;
    word_t     mem_lo;
    logic      mem_cp0_we;
    reg_addr_t mem_cp0_waddr;
    word_t     mem_cp0_wdata;
    word_t     mem_exception_type;
    word_t     mem_pc;
    logic      mem_is_in_delayslot;

    // writeback mtc0 going to CP0 and forwarded back to the stage
    logic      wb_cp0_we;
    reg_addr_t wb_cp0_waddr;
    word_t     wb_cp0_wdata;

    word_t cp0_status;
    word_t cp0_cause;
    word_t cp0_epc;

    mem_stage u_mem_stage (
        .oper_i            (oper_i),
        .mem_addr_i        (mem_addr_i),
        .mem_wdata_i       (mem_wdata_i),
        .wreg_write_i      (wreg_write_i),
        .wreg_addr_i       (wreg_addr_i),
        .wreg_data_i       (wreg_data_i),
        .whilo_i           (whilo_i),
        .hi_i              (hi_i),
        .lo_i              (lo_i),
        .cp0_we_i          (cp0_we_i),
        .cp0_waddr_i       (cp0_waddr_i),
        .cp0_wdata_i       (cp0_wdata_i),
        .exception_type_i  (exception_type_i),
        .pc_i              (pc_i),
        .is_in_delayslot_i (is_in_delayslot_i),
        .cp0_status_i      (cp0_status),
        .cp0_cause_i       (cp0_cause),
        .cp0_epc_i         (cp0_epc),
        .wb_cp0_we_i       (wb_cp0_we),
        .wb_cp0_waddr_i    (wb_cp0_waddr),
        .wb_cp0_wdata_i    (wb_cp0_wdata),
        .dmem              (dmem.master),
        .wreg_write_o      (mem_wreg_write),
        .wreg_addr_o       (mem_wreg_addr),
        .wreg_data_o       (mem_wreg_data),
        .whilo_o           (mem_whilo),
        .hi_o              (mem_hi),
        .lo_o              (mem_lo),
        .cp0_we_o          (mem_cp0_we),
        .cp0_waddr_o       (mem_cp0_waddr),
        .cp0_wdata_o       (mem_cp0_wdata),
        .exception_type_o  (mem_exception_type),
        .pc_o              (mem_pc),
        .is_in_delayslot_o (mem_is_in_delayslot),
        .cp0_epc_o         (cp0_epc_o)
    );

    data_ram u_data_ram (
        .clk  (clk),
        .dmem (dmem.slave)
    );

    mem_wb_reg u_mem_wb_reg (
        .clk              (clk),
        .reset_i          (reset_i),
        .wreg_write_i     (mem_wreg_write),
        .wreg_addr_i      (mem_wreg_addr),
        .wreg_data_i      (mem_wreg_data),
        .whilo_i          (mem_whilo),
        .hi_i             (mem_hi),
        .lo_i             (mem_lo),
        .cp0_we_i         (mem_cp0_we),
        .cp0_waddr_i      (mem_cp0_waddr),
        .cp0_wdata_i      (mem_cp0_wdata),
        .exception_type_i (mem_exception_type),
        .wreg_write_o     (wb_wreg_write_o),
        .wreg_addr_o      (wb_wreg_addr_o),
        .wreg_data_o      (wb_wreg_data_o),
        .whilo_o          (wb_whilo_o),
        .hi_o             (wb_hi_o),
        .lo_o             (wb_lo_o),
        .cp0_we_o         (wb_cp0_we),
        .cp0_waddr_o      (wb_cp0_waddr),
        .cp0_wdata_o      (wb_cp0_wdata),
        .exception_type_o (wb_exception_type_o)
    );

    cp0_regs u_cp0_regs (
        .clk               (clk),
        .reset_i           (reset_i),
        .int_i             (int_i),
        .we_i              (wb_cp0_we),
        .waddr_i           (wb_cp0_waddr),
        .wdata_i           (wb_cp0_wdata),
        .exception_type_i  (mem_exception_type),
        .pc_i              (mem_pc),
        .is_in_delayslot_i (mem_is_in_delayslot),
        .status_o          (cp0_status),
        .cause_o           (cp0_cause),
        .epc_o             (cp0_epc)
    );

endmodule

/* hw/data_ram.sv */
`timescale 1ns/1ps

module data_ram
    import mips_pkg::*;
(
    input  logic  clk,
    dmem_if.slave dmem
);

    word_t     mem_q [DMEM_DEPTH];
    dmem_idx_t idx;

    // word index with the byte offset dropped
    assign idx = dmem.addr[DMEM_AW+1:2];

    assign dmem.rdata = dmem.re ? mem_q[idx] : '0;

    always_ff @(posedge clk) begin
        if (dmem.we) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (dmem.mask[lane]) begin
                    mem_q[idx][8*lane +: 8] <= dmem.wdata[8*lane +: 8];
                end
            end
        end
    end

endmodule

/* hw/mem_wb_reg.sv */
`timescale 1ns/1ps

module mem_wb_reg
    import mips_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,

    input  logic      wreg_write_i,
    input  reg_addr_t wreg_addr_i,
    input  word_t     wreg_data_i,
    input  logic      whilo_i,
    input  word_t     hi_i,
    input  word_t     lo_i,
    input  logic      cp0_we_i,
    input  reg_addr_t cp0_waddr_i,
    input  word_t     cp0_wdata_i,
    input  word_t     exception_type_i,

    output logic      wreg_write_o,
    output reg_addr_t wreg_addr_o,
    output word_t     wreg_data_o,
    output logic      whilo_o,
    output word_t     hi_o,
    output word_t     lo_o,
    output logic      cp0_we_o,
    output reg_addr_t cp0_waddr_o,
    output word_t     cp0_wdata_o,
    output word_t     exception_type_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wreg_write_o     <= 1'b0;
            wreg_addr_o      <= '0;
            wreg_data_o      <= '0;
            whilo_o          <= 1'b0;
            hi_o             <= '0;
            lo_o             <= '0;
            cp0_we_o         <= 1'b0;
            cp0_waddr_o      <= '0;
            cp0_wdata_o      <= '0;
            exception_type_o <= EXCP_NONE;
        end else begin
            wreg_write_o     <= wreg_write_i;
            wreg_addr_o      <= wreg_addr_i;
            wreg_data_o      <= wreg_data_i;
            whilo_o          <= whilo_i;
            hi_o             <= hi_i;
            lo_o             <= lo_i;
            cp0_we_o         <= cp0_we_i;
            cp0_waddr_o      <= cp0_waddr_i;
            cp0_wdata_o      <= cp0_wdata_i;
            exception_type_o <= exception_type_i;
        end
    end

endmodule

/* hw/cp0/cp0_regs.sv */
`timescale 1ns/1ps

module cp0_regs
    import mips_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  hw_int_t   int_i,

    // mtc0 from writeback
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i,

    input  word_t     exception_type_i,
    input  word_t     pc_i,
    input  logic      is_in_delayslot_i,

    output word_t     status_o,
    output word_t     cause_o,
    output word_t     epc_o
);

    word_t status_q;
    word_t cause_q;
    word_t epc_q;
    logic [CAUSE_EXC_HI-CAUSE_EXC_LO:0] exc_code;

    // interrupts record ExcCode 0
    assign exc_code = (exception_type_i == EXCP_INTERRUPT)
                    ? '0 : exception_type_i[CAUSE_EXC_HI-CAUSE_EXC_LO:0];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            status_q <= '0;
            cause_q  <= '0;
            epc_q    <= '0;
        end else begin
            if (we_i) begin
                case (waddr_i)
                    CP0_STATUS: begin
                        status_q <= wdata_i;
                    end
                    CP0_CAUSE: begin
                        cause_q <= (cause_q & ~CP0_CAUSE_MASK) | (wdata_i & CP0_CAUSE_MASK);
                    end
                    CP0_EPC: begin
                        epc_q <= wdata_i;
                    end
                    default: begin
                    end
                endcase
            end

            // exception record overrides the mtc0 above
            if (exception_type_i == EXCP_ERET) begin
                status_q[STATUS_EXL_BIT] <= 1'b0;
            end else if (exception_type_i != EXCP_NONE) begin
                status_q[STATUS_EXL_BIT]            <= 1'b1;
                cause_q[CAUSE_EXC_HI:CAUSE_EXC_LO] <= exc_code;
                cause_q[CAUSE_BD_BIT]               <= is_in_delayslot_i;
                epc_q <= is_in_delayslot_i ? pc_i - 32'd4 : pc_i;
            end

            cause_q[CAUSE_IP_HI:CAUSE_HWIP_LO] <= int_i;
        end
    end

    assign status_o = status_q;
    assign cause_o  = cause_q;
    assign epc_o    = epc_q;

endmodule

/* hw/mem_stage/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage
    import mips_pkg::*;
(
    input  oper_t     oper_i,
    input  word_t     mem_addr_i,
    input  word_t     mem_wdata_i,

    input  logic      wreg_write_i,
    input  reg_addr_t wreg_addr_i,
    input  word_t     wreg_data_i,

    input  logic      whilo_i,
    input  word_t     hi_i,
    input  word_t     lo_i,

    input  logic      cp0_we_i,
    input  reg_addr_t cp0_waddr_i,
    input  word_t     cp0_wdata_i,

    input  word_t     exception_type_i,
    input  word_t     pc_i,
    input  logic      is_in_delayslot_i,
    input  word_t     cp0_status_i,
    input  word_t     cp0_cause_i,
    input  word_t     cp0_epc_i,

    // mtc0 sitting in writeback this cycle
    input  logic      wb_cp0_we_i,
    input  reg_addr_t wb_cp0_waddr_i,
    input  word_t     wb_cp0_wdata_i,

    dmem_if.master    dmem,

    output logic      wreg_write_o,
    output reg_addr_t wreg_addr_o,
    output word_t     wreg_data_o,

    output logic      whilo_o,
    output word_t     hi_o,
    output word_t     lo_o,

    output logic      cp0_we_o,
    output reg_addr_t cp0_waddr_o,
    output word_t     cp0_wdata_o,

    output word_t     exception_type_o,
    output word_t     pc_o,
    output logic      is_in_delayslot_o,
    output word_t     cp0_epc_o
);

    word_t status_eff;
    word_t cause_eff;
    word_t epc_eff;
    word_t exc_final;
    logic  int_pending;
    logic  excepting;

    mask_t mem_mask;
    word_t mem_wdata;
    logic  mem_we;
    logic  mem_re;
    word_t load_data;
    logic [7:0]  rd_byte;
    logic [15:0] rd_half;

    always_comb begin
        status_eff = cp0_status_i;
        cause_eff  = cp0_cause_i;
        epc_eff    = cp0_epc_i;
        if (wb_cp0_we_i) begin
            case (wb_cp0_waddr_i)
                CP0_STATUS: begin
                    status_eff = wb_cp0_wdata_i;
                end
                CP0_CAUSE: begin
                    cause_eff = (cp0_cause_i & ~CP0_CAUSE_MASK)
                              | (wb_cp0_wdata_i & CP0_CAUSE_MASK);
                end
                CP0_EPC: begin
                    epc_eff = wb_cp0_wdata_i;
                end
                default: begin
                end
            endcase
        end
    end

    assign int_pending = (|(cause_eff[CAUSE_IP_HI:CAUSE_IP_LO]
                            & status_eff[STATUS_IM_HI:STATUS_IM_LO]))
                         && !status_eff[STATUS_EXL_BIT]
                         && status_eff[STATUS_IE_BIT];

    // interrupt wins, then the flags in fixed order
    always_comb begin
        exc_final = EXCP_NONE;
        if (pc_i != PC_RESET_ADDR) begin
            if (int_pending) begin
                exc_final = EXCP_INTERRUPT;
            end else if (exception_type_i[EXC_BIT_SYSCALL]) begin
                exc_final = EXCP_SYSCALL;
            end else if (exception_type_i[EXC_BIT_INVALID]) begin
                exc_final = EXCP_INVALID_INST;
            end else if (exception_type_i[EXC_BIT_OV]) begin
                exc_final = EXCP_OV;
            end else if (exception_type_i[EXC_BIT_ERET]) begin
                exc_final = EXCP_ERET;
            end
        end
    end

    assign excepting = (exc_final != EXCP_NONE);

    // lane picked by the low address bits
    assign rd_byte = dmem.rdata[8*mem_addr_i[1:0] +: 8];
    assign rd_half = dmem.rdata[16*mem_addr_i[1] +: 16];

    always_comb begin
        mem_mask  = 4'b0000;
        mem_wdata = '0;
        mem_we    = 1'b0;
        mem_re    = 1'b0;
        load_data = wreg_data_i;
        case (oper_i)
            OP_LB, OP_LBU: begin
                mem_re    = 1'b1;
                mem_mask  = 4'b0001 << mem_addr_i[1:0];
                load_data = (oper_i == OP_LB) ? {{24{rd_byte[7]}}, rd_byte}
                                              : {24'b0, rd_byte};
            end
            OP_LH, OP_LHU: begin
                mem_re = 1'b1;
                // odd halfword address reads nothing
                if (mem_addr_i[0]) begin
                    load_data = '0;
                end else begin
                    mem_mask  = mem_addr_i[1] ? 4'b1100 : 4'b0011;
                    load_data = (oper_i == OP_LH) ? {{16{rd_half[15]}}, rd_half}
                                                  : {16'b0, rd_half};
                end
            end
            OP_LW: begin
                mem_re    = 1'b1;
                mem_mask  = 4'b1111;
                load_data = dmem.rdata;
            end
            OP_SB: begin
                mem_we    = 1'b1;
                mem_wdata = {4{mem_wdata_i[7:0]}};
                mem_mask  = 4'b0001 << mem_addr_i[1:0];
            end
            OP_SH: begin
                mem_we    = 1'b1;
                mem_wdata = {2{mem_wdata_i[15:0]}};
                if (!mem_addr_i[0]) begin
                    mem_mask = mem_addr_i[1] ? 4'b1100 : 4'b0011;
                end
            end
            OP_SW: begin
                mem_we    = 1'b1;
                mem_wdata = mem_wdata_i;
                mem_mask  = 4'b1111;
            end
            default: begin
            end
        endcase
    end

    assign dmem.addr  = mem_addr_i;
    assign dmem.wdata = mem_wdata;
    assign dmem.we    = mem_we & ~excepting;
    assign dmem.re    = mem_re;
    assign dmem.mask  = mem_mask;

    // an excepting instruction writes nothing back
    assign wreg_write_o = wreg_write_i & ~excepting;
    assign wreg_addr_o  = wreg_addr_i;
    assign wreg_data_o  = load_data;

    assign whilo_o = whilo_i & ~excepting;
    assign hi_o    = hi_i;
    assign lo_o    = lo_i;

    assign cp0_we_o    = cp0_we_i & ~excepting;
    assign cp0_waddr_o = cp0_waddr_i;
    assign cp0_wdata_o = cp0_wdata_i;

    assign exception_type_o  = exc_final;
    assign pc_o              = pc_i;
    assign is_in_delayslot_o = is_in_delayslot_i;
    assign cp0_epc_o         = epc_eff;

endmodule

/* common/dmem_if.sv */
`timescale 1ns/1ps

interface dmem_if
    import mips_pkg::*;
();

    word_t addr;
    word_t wdata;
    logic  we;
    logic  re;
    mask_t mask;
    word_t rdata;

    modport master (
        output addr,
        output wdata,
        output we,
        output re,
        output mask,
        input  rdata
    );

    modport slave (
        input  addr,
        input  wdata,
        input  we,
        input  re,
        input  mask,
        output rdata
    );

endinterface

/* common/mips_pkg.sv */
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  mask_t;

    localparam int HW_INT_W = 6;
    typedef logic [HW_INT_W-1:0] hw_int_t;

    localparam int DMEM_DEPTH = 256;
    localparam int DMEM_AW    = $clog2(DMEM_DEPTH);
    typedef logic [DMEM_AW-1:0] dmem_idx_t;

    // memory operation handed over by execute
    typedef enum logic [3:0] {
        OP_NONE = 4'd0,
        OP_LB   = 4'd1,
        OP_LBU  = 4'd2,
        OP_LH   = 4'd3,
        OP_LHU  = 4'd4,
        OP_LW   = 4'd5,
        OP_SB   = 4'd6,
        OP_SH   = 4'd7,
        OP_SW   = 4'd8,
        OP_ERET = 4'd9
    } oper_t;

    // flag positions in the incoming exception word
    localparam int EXC_BIT_SYSCALL = 8;
    localparam int EXC_BIT_INVALID = 9;
    localparam int EXC_BIT_OV      = 11;
    localparam int EXC_BIT_ERET    = 12;

    // final exception codes, also the ExcCode written to Cause
    localparam word_t EXCP_NONE         = 32'd0;
    localparam word_t EXCP_INTERRUPT    = 32'd1;
    localparam word_t EXCP_SYSCALL      = 32'd8;
    localparam word_t EXCP_INVALID_INST = 32'd10;
    localparam word_t EXCP_OV           = 32'd12;
    localparam word_t EXCP_ERET         = 32'd14;

    localparam reg_addr_t CP0_STATUS = 5'd12;
    localparam reg_addr_t CP0_CAUSE  = 5'd13;
    localparam reg_addr_t CP0_EPC    = 5'd14;

    localparam int STATUS_IE_BIT  = 0;
    localparam int STATUS_EXL_BIT = 1;
    localparam int STATUS_IM_LO   = 8;
    localparam int STATUS_IM_HI   = 15;

    localparam int CAUSE_EXC_LO  = 2;
    localparam int CAUSE_EXC_HI  = 6;
    localparam int CAUSE_IP_LO   = 8;
    localparam int CAUSE_HWIP_LO = 10;
    localparam int CAUSE_IP_HI   = 15;
    localparam int CAUSE_BD_BIT  = 31;

    // only the two software interrupt bits are writable
    localparam word_t CP0_CAUSE_MASK = 32'h0000_0300;

    localparam word_t PC_RESET_ADDR = 32'hbfc0_0000;

endpackage
